//--- Makefile
VERILATOR ?= verilator
TOP       ?= execCoreTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMARGS   ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIMARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
  import execPkg::*;
(
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  aluOpT                op,
  output logic [dataWidth-1:0] result,
  output logic                 zero
);

  logic [4:0] shamt;

  assign shamt = b[4:0];  // RV32I shift amount

  always_comb begin
    case (op)
      aluAdd:   result = a + b;
      aluSub:   result = a - b;
      aluAnd:   result = a & b;
      aluOr:    result = a | b;
      aluXor:   result = a ^ b;
      aluSlt: begin
        result = '0;
        result[0] = ($signed(a) < $signed(b));
      end
      aluSltu: begin
        result = '0;
        result[0] = (a < b);
      end
      aluSll:   result = a << shamt;
      aluSrl:   result = a >> shamt;
      aluSra:   result = $unsigned($signed(a) >>> shamt);  // Sign fill
      aluPassB: result = b;
      default:  result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- design/branchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module branchUnit
  import execPkg::*;
(
  input  branchKindT           kind,
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  output logic                 taken
);

  logic equal;
  logic lessSigned;
  logic lessUnsigned;

  assign equal        = (a == b);
  assign lessSigned   = ($signed(a) < $signed(b));
  assign lessUnsigned = (a < b);

  always_comb begin
    case (kind)
      brBeq:   taken = equal;
      brBne:   taken = !equal;
      brBlt:   taken = lessSigned;
      brBge:   taken = !lessSigned;
      brBltu:  taken = lessUnsigned;
      brBgeu:  taken = !lessUnsigned;
      brJal:   taken = 1'b1;   // Unconditional
      default: taken = 1'b0;   // Not a branch
    endcase
  end

endmodule

`default_nettype wire

//--- design/execCore.sv
`timescale 1ns/100ps
`default_nettype none

module execCore
  import execPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [regAddrWidth-1:0] rs1D,
  input  logic [regAddrWidth-1:0] rs2D,
  input  logic [regAddrWidth-1:0] rdD,
  input  logic [dataWidth-1:0]    immD,
  input  logic [dataWidth-1:0]    pcD,
  input  logic                    regWriteD,
  input  logic                    memWriteD,
  input  logic                    aluSrcD,
  input  aluOpT                   aluOpD,
  input  branchKindT              branchKindD,
  input  resultSrcT               resultSrcD,
  output logic                    stallD,
  output logic                    pcSrcE,
  output logic [dataWidth-1:0]    pcTargetE,
  output logic                    regWriteW,
  output logic [regAddrWidth-1:0] rdW,
  output logic [dataWidth-1:0]    resultW
);

  logic [dataWidth-1:0]    rd1D;
  logic [dataWidth-1:0]    rd2D;
  fwdSelT                  forwardA;
  fwdSelT                  forwardB;
  logic                    flushE;
  logic [regAddrWidth-1:0] rs1E;
  logic [regAddrWidth-1:0] rs2E;
  logic [regAddrWidth-1:0] rdE;
  resultSrcT               resultSrcE;
  logic                    regWriteE;
  logic                    memWriteE;
  logic [dataWidth-1:0]    aluResultE;
  logic [dataWidth-1:0]    writeDataE;
  logic [dataWidth-1:0]    pcPlus4E;

  fwdIf fwdBus ();  // Later-stage results for forwarding

  regFile regs (
    .clk(clk), .reset(reset), .rs1(rs1D), .rs2(rs2D), .rd1(rd1D), .rd2(rd2D),
    .writeEnable(fwdBus.regWriteW), .writeAddr(fwdBus.rdW), .writeData(fwdBus.resultW)
  );

  hazardUnit hazard (
    .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE),
    .resultSrcE(resultSrcE), .pcSrcE(pcSrcE), .fwd(fwdBus.hazard),
    .forwardA(forwardA), .forwardB(forwardB), .stallD(stallD), .flushE(flushE)
  );

  execStage exec (
    .clk(clk), .reset(reset), .flushE(flushE),
    .rd1D(rd1D), .rd2D(rd2D), .immD(immD), .pcD(pcD), .rdD(rdD), .rs1D(rs1D), .rs2D(rs2D),
    .regWriteD(regWriteD), .memWriteD(memWriteD), .aluSrcD(aluSrcD), .aluOpD(aluOpD),
    .branchKindD(branchKindD), .resultSrcD(resultSrcD),
    .forwardA(forwardA), .forwardB(forwardB), .fwd(fwdBus.exec),
    .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE), .resultSrcE(resultSrcE),
    .regWriteE(regWriteE), .memWriteE(memWriteE), .aluResultE(aluResultE),
    .writeDataE(writeDataE), .pcPlus4E(pcPlus4E), .pcSrcE(pcSrcE), .pcTargetE(pcTargetE)
  );

  memStage mem (
    .clk(clk), .reset(reset), .regWriteE(regWriteE), .memWriteE(memWriteE),
    .resultSrcE(resultSrcE), .rdE(rdE), .aluResultE(aluResultE),
    .writeDataE(writeDataE), .pcPlus4E(pcPlus4E), .fwd(fwdBus.src)
  );

  assign regWriteW = fwdBus.regWriteW;  // Writeback report
  assign rdW       = fwdBus.rdW;
  assign resultW   = fwdBus.resultW;

endmodule

`default_nettype wire

//--- design/execPkg.sv
`default_nettype none

package execPkg;

  localparam int dataWidth    = 32;                  // Data and address width
  localparam int regAddrWidth = 5;                   // Register index width
  localparam int memWords     = 64;                  // Data memory depth in words
  localparam int memAddrWidth = $clog2(memWords);    // Word index width

  typedef enum logic [3:0] {
    aluAdd   = 4'd0,
    aluSub   = 4'd1,
    aluAnd   = 4'd2,
    aluOr    = 4'd3,
    aluXor   = 4'd4,
    aluSlt   = 4'd5,
    aluSltu  = 4'd6,
    aluSll   = 4'd7,
    aluSrl   = 4'd8,
    aluSra   = 4'd9,
    aluPassB = 4'd10   // lui passes the immediate
  } aluOpT;

  typedef enum logic [2:0] {
    brNone = 3'd0,
    brBeq  = 3'd1,
    brBne  = 3'd2,
    brBlt  = 3'd3,
    brBge  = 3'd4,
    brBltu = 3'd5,
    brBgeu = 3'd6,
    brJal  = 3'd7
  } branchKindT;

  typedef enum logic [1:0] {
    resAlu     = 2'd0,
    resMem     = 2'd1,
    resPcPlus4 = 2'd2   // Link value for jal
  } resultSrcT;

  typedef enum logic [1:0] {
    fwdRegFile   = 2'd0,
    fwdWriteback = 2'd1,
    fwdMemory    = 2'd2
  } fwdSelT;

endpackage

`default_nettype wire

//--- design/execStage.sv
`timescale 1ns/100ps
`default_nettype none

module execStage
  import execPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    flushE,
  input  logic [dataWidth-1:0]    rd1D,
  input  logic [dataWidth-1:0]    rd2D,
  input  logic [dataWidth-1:0]    immD,
  input  logic [dataWidth-1:0]    pcD,
  input  logic [regAddrWidth-1:0] rdD,
  input  logic [regAddrWidth-1:0] rs1D,
  input  logic [regAddrWidth-1:0] rs2D,
  input  logic                    regWriteD,
  input  logic                    memWriteD,
  input  logic                    aluSrcD,
  input  aluOpT                   aluOpD,
  input  branchKindT              branchKindD,
  input  resultSrcT               resultSrcD,
  input  fwdSelT                  forwardA,
  input  fwdSelT                  forwardB,
  fwdIf.exec                      fwd,
  output logic [regAddrWidth-1:0] rs1E,
  output logic [regAddrWidth-1:0] rs2E,
  output logic [regAddrWidth-1:0] rdE,
  output resultSrcT               resultSrcE,
  output logic                    regWriteE,
  output logic                    memWriteE,
  output logic [dataWidth-1:0]    aluResultE,
  output logic [dataWidth-1:0]    writeDataE,
  output logic [dataWidth-1:0]    pcPlus4E,
  output logic                    pcSrcE,
  output logic [dataWidth-1:0]    pcTargetE
);

  logic [dataWidth-1:0] rd1E;
  logic [dataWidth-1:0] rd2E;
  logic [dataWidth-1:0] immE;
  logic [dataWidth-1:0] pcE;
  logic                 aluSrcE;
  aluOpT                aluOpE;
  branchKindT           branchKindE;
  logic [dataWidth-1:0] srcAE;
  logic [dataWidth-1:0] srcBE;

  // Decode to execute register, a flush turns the slot into a bubble
  always_ff @(posedge clk) begin
    if (reset || flushE) begin
      rd1E        <= '0;
      rd2E        <= '0;
      immE        <= '0;
      pcE         <= '0;
      rdE         <= '0;
      rs1E        <= '0;
      rs2E        <= '0;
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      aluSrcE     <= 1'b0;
      aluOpE      <= aluAdd;
      branchKindE <= brNone;
      resultSrcE  <= resAlu;
    end else begin
      rd1E        <= rd1D;
      rd2E        <= rd2D;
      immE        <= immD;
      pcE         <= pcD;
      rdE         <= rdD;
      rs1E        <= rs1D;
      rs2E        <= rs2D;
      regWriteE   <= regWriteD;
      memWriteE   <= memWriteD;
      aluSrcE     <= aluSrcD;
      aluOpE      <= aluOpD;
      branchKindE <= branchKindD;
      resultSrcE  <= resultSrcD;
    end
  end

  always_comb begin
    case (forwardA)
      fwdWriteback: srcAE = fwd.resultW;
      fwdMemory:    srcAE = fwd.aluResultM;
      default:      srcAE = rd1E;
    endcase
  end

  always_comb begin
    case (forwardB)
      fwdWriteback: writeDataE = fwd.resultW;
      fwdMemory:    writeDataE = fwd.aluResultM;
      default:      writeDataE = rd2E;
    endcase
  end

  assign srcBE = aluSrcE ? immE : writeDataE;  // Immediate forms

  alu aluInst (
    .a      (srcAE),
    .b      (srcBE),
    .op     (aluOpE),
    .result (aluResultE),
    .zero   ()
  );

  // Compares register operands, never the immediate
  branchUnit branchInst (
    .kind  (branchKindE),
    .a     (srcAE),
    .b     (writeDataE),
    .taken (pcSrcE)
  );

  assign pcTargetE = pcE + immE;
  assign pcPlus4E  = pcE + dataWidth'(4);

endmodule

`default_nettype wire

//--- design/fwdIf.sv
`timescale 1ns/100ps
`default_nettype none

interface fwdIf
  import execPkg::*;
();

  logic [dataWidth-1:0]    aluResultM;
  logic [regAddrWidth-1:0] rdM;
  logic                    regWriteM;
  resultSrcT               resultSrcM;
  logic [dataWidth-1:0]    resultW;
  logic [regAddrWidth-1:0] rdW;
  logic                    regWriteW;

  modport src (output aluResultM, rdM, regWriteM, resultSrcM, resultW, rdW, regWriteW);
  modport exec (input aluResultM, resultW);  // Forwarded operand values
  modport hazard (input rdM, regWriteM, resultSrcM, rdW, regWriteW);

endinterface

`default_nettype wire

//--- design/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit
  import execPkg::*;
(
  input  logic [regAddrWidth-1:0] rs1D,
  input  logic [regAddrWidth-1:0] rs2D,
  input  logic [regAddrWidth-1:0] rs1E,
  input  logic [regAddrWidth-1:0] rs2E,
  input  logic [regAddrWidth-1:0] rdE,
  input  resultSrcT               resultSrcE,
  input  logic                    pcSrcE,
  fwdIf.hazard                    fwd,
  output fwdSelT                  forwardA,
  output fwdSelT                  forwardB,
  output logic                    stallD,
  output logic                    flushE
);

  logic memReady;
  logic wbReady;
  logic loadUse;

  // Only ALU results exist in M, load data shows up in W
  assign memReady = fwd.regWriteM && (fwd.rdM != '0) && (fwd.resultSrcM == resAlu);
  assign wbReady  = fwd.regWriteW && (fwd.rdW != '0);

  always_comb begin
    if (memReady && fwd.rdM == rs1E) forwardA = fwdMemory;  // Newest value wins
    else if (wbReady && fwd.rdW == rs1E) forwardA = fwdWriteback;
    else forwardA = fwdRegFile;
  end

  always_comb begin
    if (memReady && fwd.rdM == rs2E) forwardB = fwdMemory;
    else if (wbReady && fwd.rdW == rs2E) forwardB = fwdWriteback;
    else forwardB = fwdRegFile;
  end

  assign loadUse = (resultSrcE == resMem) && (rdE != '0) && ((rdE == rs1D) || (rdE == rs2D));

  assign stallD = loadUse;
  assign flushE = loadUse | pcSrcE;  // Bubble or wrong-path squash

endmodule

`default_nettype wire

//--- design/memStage.sv
`timescale 1ns/100ps
`default_nettype none

module memStage
  import execPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    regWriteE,
  input  logic                    memWriteE,
  input  resultSrcT               resultSrcE,
  input  logic [regAddrWidth-1:0] rdE,
  input  logic [dataWidth-1:0]    aluResultE,
  input  logic [dataWidth-1:0]    writeDataE,
  input  logic [dataWidth-1:0]    pcPlus4E,
  fwdIf.src                       fwd
);

  logic                    regWriteM;
  logic                    memWriteM;
  resultSrcT               resultSrcM;
  logic [regAddrWidth-1:0] rdM;
  logic [dataWidth-1:0]    aluResultM;
  logic [dataWidth-1:0]    writeDataM;
  logic [dataWidth-1:0]    pcPlus4M;
  logic [memAddrWidth-1:0] wordIdx;
  logic [dataWidth-1:0]    readDataM;
  logic                    regWriteW;
  resultSrcT               resultSrcW;
  logic [regAddrWidth-1:0] rdW;
  logic [dataWidth-1:0]    aluResultW;
  logic [dataWidth-1:0]    readDataW;
  logic [dataWidth-1:0]    pcPlus4W;
  logic [dataWidth-1:0]    dataMem [memWords];

  always_ff @(posedge clk) begin
    if (reset) begin
      regWriteM  <= 1'b0;
      memWriteM  <= 1'b0;
      resultSrcM <= resAlu;
      regWriteW  <= 1'b0;
      resultSrcW <= resAlu;
    end else begin
      regWriteM  <= regWriteE;
      memWriteM  <= memWriteE;
      resultSrcM <= resultSrcE;
      regWriteW  <= regWriteM;
      resultSrcW <= resultSrcM;
    end
  end

  always_ff @(posedge clk) begin
    rdM        <= rdE;
    aluResultM <= aluResultE;
    writeDataM <= writeDataE;
    pcPlus4M   <= pcPlus4E;
    rdW        <= rdM;
    aluResultW <= aluResultM;
    readDataW  <= readDataM;
    pcPlus4W   <= pcPlus4M;
  end

  assign wordIdx   = aluResultM[memAddrWidth+1:2];  // Word aligned only
  assign readDataM = dataMem[wordIdx];              // Async read in M

  always_ff @(posedge clk) begin
    if (memWriteM) dataMem[wordIdx] <= writeDataM;  // Store lands at end of M
  end

  assign fwd.aluResultM = aluResultM;
  assign fwd.rdM        = rdM;
  assign fwd.regWriteM  = regWriteM;
  assign fwd.resultSrcM = resultSrcM;
  assign fwd.rdW        = rdW;
  assign fwd.regWriteW  = regWriteW;

  always_comb begin
    case (resultSrcW)
      resMem:     fwd.resultW = readDataW;
      resPcPlus4: fwd.resultW = pcPlus4W;   // jal link
      default:    fwd.resultW = aluResultW;
    endcase
  end

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile
  import execPkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic [regAddrWidth-1:0] rs1,
  input  logic [regAddrWidth-1:0] rs2,
  output logic [dataWidth-1:0]    rd1,
  output logic [dataWidth-1:0]    rd2,
  input  logic                    writeEnable,
  input  logic [regAddrWidth-1:0] writeAddr,
  input  logic [dataWidth-1:0]    writeData
);

  logic [dataWidth-1:0] regs [2**regAddrWidth];
  logic                 writeLive;

  assign writeLive = writeEnable && (writeAddr != '0);  // x0 stays zero

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (writeLive) begin
      regs[writeAddr] <= writeData;
    end
  end

  always_comb begin
    if (rs1 == '0) rd1 = '0;
    else if (writeLive && writeAddr == rs1) rd1 = writeData;  // Bypass W write
    else rd1 = regs[rs1];
  end

  always_comb begin
    if (rs2 == '0) rd2 = '0;
    else if (writeLive && writeAddr == rs2) rd2 = writeData;
    else rd2 = regs[rs2];
  end

endmodule

`default_nettype wire

//--- tb/execCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module execCoreTb
  import execPkg::*;
();

  localparam int stimWords = 128;
  localparam int expBase   = 64;    // Expected writebacks start here
  localparam int waitLimit = 2000;  // Cycles

  logic                    clk;
  logic                    reset;
  logic [regAddrWidth-1:0] rs1D;
  logic [regAddrWidth-1:0] rs2D;
  logic [regAddrWidth-1:0] rdD;
  logic [dataWidth-1:0]    immD;
  logic [dataWidth-1:0]    pcD;
  logic                    regWriteD;
  logic                    memWriteD;
  logic                    aluSrcD;
  aluOpT                   aluOpD;
  branchKindT              branchKindD;
  resultSrcT               resultSrcD;
  logic                    stallD;
  logic                    pcSrcE;
  logic [dataWidth-1:0]    pcTargetE;
  logic                    regWriteW;
  logic [regAddrWidth-1:0] rdW;
  logic [dataWidth-1:0]    resultW;

  logic [79:0]          stimMem [stimWords];
  logic [79:0]          expEntry;
  logic [dataWidth-1:0] pc;
  logic [dataWidth-1:0] nextPc;
  logic [6:0]           slot;
  int                   expCount = 0;
  int                   expIdx = 0;
  int                   waitCycles;

  execCore dut (
    .clk(clk), .reset(reset), .rs1D(rs1D), .rs2D(rs2D), .rdD(rdD), .immD(immD), .pcD(pcD),
    .regWriteD(regWriteD), .memWriteD(memWriteD), .aluSrcD(aluSrcD), .aluOpD(aluOpD),
    .branchKindD(branchKindD), .resultSrcD(resultSrcD), .stallD(stallD), .pcSrcE(pcSrcE),
    .pcTargetE(pcTargetE), .regWriteW(regWriteW), .rdW(rdW), .resultW(resultW)
  );

  bind execCore execCoreProps props (
    .clk(clk), .reset(reset), .stallD(stallD), .pcSrcE(pcSrcE), .regWriteW(regWriteW)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic stopOnFailure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // Unpacks one program word onto the decode ports
  task automatic presentInstr(input logic [79:0] word, input logic [31:0] addr);
    regWriteD   <= word[76];
    memWriteD   <= word[72];
    aluSrcD     <= word[68];
    aluOpD      <= aluOpT'(word[67:64]);
    branchKindD <= branchKindT'(word[62:60]);
    resultSrcD  <= resultSrcT'(word[57:56]);
    rdD         <= word[52:48];
    rs1D        <= word[44:40];
    rs2D        <= word[36:32];
    immD        <= word[31:0];
    pcD         <= addr;
  endtask

  // Fetch model
  always @(posedge clk) begin
    if (reset) nextPc = '0;
    else if (stallD) nextPc = pc;         // Hold the decode slot
    else if (pcSrcE) nextPc = pcTargetE;  // Redirect after wrong-path slot
    else nextPc = pc + 32'd4;
    slot = {1'b0, nextPc[7:2]};
    pc <= nextPc;
    presentInstr(stimMem[slot], nextPc);
  end

  // Writeback checker
  always @(posedge clk) begin
    if (!reset && dut.props.failCount != 0) begin
      stopOnFailure("A pipeline control assertion failed");
    end
    if (!reset && regWriteW && rdW != '0) begin
      if (expIdx >= expCount) begin
        stopOnFailure($sformatf("Unexpected writeback to x%0d after the expected sequence", rdW));
      end else begin
        expEntry = stimMem[7'(expBase + expIdx)];
        checkValue($sformatf("writeback %0d rd", expIdx), 32'(expEntry[55:48]), 32'(rdW));
        checkValue($sformatf("writeback %0d x%0d", expIdx, rdW), expEntry[31:0], resultW);
        expIdx++;
      end
    end
  end

  initial begin
    reset       = 1'b1;
    rs1D        = '0;
    rs2D        = '0;
    rdD         = '0;
    immD        = '0;
    pcD         = '0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    aluSrcD     = 1'b0;
    aluOpD      = aluAdd;
    branchKindD = brNone;
    resultSrcD  = resAlu;
    for (int i = 0; i < stimWords; i++) begin
      stimMem[7'(i)] = '0;  // Empty slots decode as nops
    end
    $readmemh("tb/execStimulus.txt", stimMem);
    while (expCount < stimWords - expBase && stimMem[7'(expBase + expCount)][79:76] == 4'hF) begin
      expCount++;
    end
    if (expCount == 0) stopOnFailure("No expected writebacks found in the stimulus file");

    repeat (5) @(posedge clk);
    reset <= 1'b0;
    // First instruction needs three edges to reach W
    repeat (3) begin
      @(posedge clk);
      checkValue("quiet after reset", 32'd0, 32'(regWriteW));
    end

    waitCycles = 0;
    while (expIdx < expCount && waitCycles < waitLimit) begin
      @(negedge clk);
      waitCycles++;
    end
    if (expIdx < expCount) begin
      stopOnFailure($sformatf("Timed out with %0d of %0d writebacks seen", expIdx, expCount));
    end
    repeat (8) @(posedge clk);  // Let stray writebacks surface

    if (dut.props.failCount == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- tb/execCore_props.sv
`timescale 1ns/100ps
`default_nettype none

module execCoreProps (
  input logic clk,
  input logic reset,
  input logic stallD,
  input logic pcSrcE,
  input logic regWriteW
);

  int failCount = 0;  // Polled by the testbench

  // Pipeline registers are clear once reset has seen one edge
  quietControlInReset: assert property (
    @(posedge clk) (reset && $past(reset)) |-> (!stallD && !pcSrcE))
    else begin
      failCount++;
      $error("stallD or pcSrcE high while reset is held");
    end

  // A load-use hazard inserts exactly one bubble
  singleStall: assert property (
    @(posedge clk) disable iff (reset) stallD |=> !stallD)
    else begin
      failCount++;
      $error("stallD high for two consecutive cycles");
    end

  noWritebackInReset: assert property (
    @(posedge clk) (reset && $past(reset)) |-> !regWriteW)
    else begin
      failCount++;
      $error("regWriteW high while reset is held");
    end

endmodule

`default_nettype wire

//--- tb/execStimulus.txt
// Program at word PC/4: regWrite_memWrite_aluSrc_aluOp_branch_resultSrc_rd_rs1_rs2_imm
// Expected writebacks from @40: F marker, rd in the rd column, value in the imm column
1_0_1_0_0_0_01_00_00_00000005 // addi x1, x0, 5
1_0_1_0_0_0_02_00_00_FFFFFFFD // addi x2, x0, -3
1_0_0_0_0_0_03_01_02_00000000 // add  x3, x1, x2
1_0_0_1_0_0_04_03_01_00000000 // sub  x4, x3, x1
1_0_0_4_0_0_05_04_03_00000000 // xor  x5, x4, x3
1_0_0_2_0_0_06_05_01_00000000 // and  x6, x5, x1
1_0_0_3_0_0_07_06_02_00000000 // or   x7, x6, x2
1_0_0_5_0_0_08_02_01_00000000 // slt  x8, x2, x1
1_0_0_6_0_0_09_02_01_00000000 // sltu x9, x2, x1
1_0_0_7_0_0_0A_01_03_00000000 // sll  x10, x1, x3
1_0_1_9_0_0_0B_02_00_00000021 // srai x11, x2, 33
1_0_0_8_0_0_0C_02_01_00000000 // srl  x12, x2, x1
1_0_1_A_0_0_0D_00_00_12345000 // lui  x13, 0x12345
1_0_1_0_0_0_0E_00_00_00000007 // addi x14, x0, 7
1_0_1_0_0_0_0E_0E_00_00000001 // addi x14, x14, 1
1_0_0_0_0_0_0F_0E_0E_00000000 // add  x15, x14, x14
0_1_1_0_0_0_00_0F_0D_00000004 // sw   x13, 4(x15)
1_0_1_0_0_1_10_0F_00_00000004 // lw   x16, 4(x15)
1_0_0_0_0_0_11_10_01_00000000 // add  x17, x16, x1
1_0_1_0_0_0_00_01_00_00000009 // addi x0, x1, 9
1_0_0_0_0_0_12_00_01_00000000 // add  x18, x0, x1
0_0_0_0_1_0_00_01_02_0000006C // beq  x1, x2, trap
0_0_0_0_1_0_00_01_12_00000008 // beq  x1, x18, +8
1_0_1_0_0_0_1F_00_00_00000BAD // wrong path
0_0_0_0_2_0_00_01_12_00000060 // bne  x1, x18, trap
0_0_0_0_2_0_00_01_02_00000008 // bne  x1, x2, +8
1_0_1_0_0_0_1F_00_00_00000BAD // wrong path
0_0_0_0_3_0_00_01_02_00000054 // blt  x1, x2, trap
0_0_0_0_3_0_00_02_01_00000008 // blt  x2, x1, +8
1_0_1_0_0_0_1F_00_00_00000BAD // wrong path
0_0_0_0_4_0_00_02_01_00000048 // bge  x2, x1, trap
0_0_0_0_4_0_00_01_02_00000008 // bge  x1, x2, +8
1_0_1_0_0_0_1F_00_00_00000BAD // wrong path
0_0_0_0_5_0_00_02_01_0000003C // bltu x2, x1, trap
0_0_0_0_5_0_00_01_02_00000008 // bltu x1, x2, +8
1_0_1_0_0_0_1F_00_00_00000BAD // wrong path
0_0_0_0_6_0_00_01_02_00000030 // bgeu x1, x2, trap
0_0_0_0_6_0_00_02_01_00000008 // bgeu x2, x1, +8
1_0_1_0_0_0_1F_00_00_00000BAD // wrong path
1_0_0_0_7_2_13_00_00_00000008 // jal  x19, +8
1_0_1_0_0_0_1F_00_00_00000BAD // wrong path
1_0_1_0_0_0_14_13_00_00000001 // addi x20, x19, 1
1_0_0_0_7_2_00_00_00_00000000 // jal  x0, 0 (halt)
@30
1_0_1_0_0_0_1F_00_00_00000BAD // trap, reached only by a wrong branch
1_0_0_0_7_2_00_00_00_00000000 // jal  x0, 0
@40
F_0_0_0_0_0_01_00_00_00000005
F_0_0_0_0_0_02_00_00_FFFFFFFD
F_0_0_0_0_0_03_00_00_00000002
F_0_0_0_0_0_04_00_00_FFFFFFFD
F_0_0_0_0_0_05_00_00_FFFFFFFF
F_0_0_0_0_0_06_00_00_00000005
F_0_0_0_0_0_07_00_00_FFFFFFFD
F_0_0_0_0_0_08_00_00_00000001
F_0_0_0_0_0_09_00_00_00000000
F_0_0_0_0_0_0A_00_00_00000014
F_0_0_0_0_0_0B_00_00_FFFFFFFE
F_0_0_0_0_0_0C_00_00_07FFFFFF
F_0_0_0_0_0_0D_00_00_12345000
F_0_0_0_0_0_0E_00_00_00000007
F_0_0_0_0_0_0E_00_00_00000008
F_0_0_0_0_0_0F_00_00_00000010
F_0_0_0_0_0_10_00_00_12345000
F_0_0_0_0_0_11_00_00_12345005
F_0_0_0_0_0_12_00_00_00000005
F_0_0_0_0_0_13_00_00_000000A0
F_0_0_0_0_0_14_00_00_000000A1

//--- verilog.f
design/execPkg.sv
design/fwdIf.sv
design/regFile.sv
design/alu.sv
design/branchUnit.sv
design/hazardUnit.sv
design/execStage.sv
design/memStage.sv
design/execCore.sv
tb/execCore_props.sv
tb/execCoreTb.sv
